// ==== verilog/cfeb_pkg.sv ====
`default_nettype none

package cfeb_pkg;

   ////////////////////////////////////////
   // board geometry
   ////////////////////////////////////////
   localparam int N_CH   = 16;            // channels per board
   localparam int N_GRP  = 6;             // time-multiplexed input groups
   localparam int SAMP_W = 12;            // one adc sample
   localparam int GRP_W  = N_CH * SAMP_W; // 192, all channels of one group
   localparam int SMAX_W = 7;             // sample counter / samp_max
   localparam int SEL_W  = 3;             // group select, counts 0..5
   localparam int ADR_W  = 4;             // wishbone channel address

   ////////////////////////////////////////
   // data types
   ////////////////////////////////////////
   typedef logic [GRP_W-1:0] group_word_t;   // ch0 in bits 11:0

   // g1 sits in the low bits
   typedef struct packed {
      group_word_t g6;
      group_word_t g5;
      group_word_t g4;
      group_word_t g3;
      group_word_t g2;
      group_word_t g1;
   } grp_bus_t;

   typedef struct packed {
      logic        en;     // common write enable, all fifos
      group_word_t data;   // one slice per channel
   } fifo_wr_t;

   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;    // writes are acked and ignored
      logic [ADR_W-1:0] adr;   // channel number
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [SAMP_W-1:0] dat;
   } wb_rsp_t;

   typedef enum logic {
      IDLE = 1'b0,   // waiting for aligned trigger
      LOAD = 1'b1    // stepping through groups
   } load_state_e;

endpackage

`default_nettype wire

// ==== verilog/trigger_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module trigger_align (
   input  wire logic WRCLK,
   input  wire logic srst,
   input  wire logic l1a_match,   // raw trigger match
   input  wire logic smpclk,      // sample clock, async to WRCLK
   output logic      start        // one-shot per aligned trigger
);

   logic l1a_d1;        // trigger delayed one clock
   logic smp_s1;        // sync stage 1
   logic smp_s2;        // sync stage 2
   logic stretch_l1a;   // trigger held for two cycles
   logic phase_ok;      // sample clock low, raw and synced

   assign stretch_l1a = l1a_match | l1a_d1;
   assign phase_ok    = ~smpclk & ~smp_s2;   // both views must agree

   ////////////////////////////////////////
   // stretch, sync and start register
   ////////////////////////////////////////
   always_ff @(posedge WRCLK or posedge srst) begin
      if (srst) begin
         l1a_d1 <= 1'b0;
         smp_s1 <= 1'b0;
         smp_s2 <= 1'b0;
         start  <= 1'b0;
      end else begin
         l1a_d1 <= l1a_match;
         smp_s1 <= smpclk;                   // metastability stage
         smp_s2 <= smp_s1;
         start  <= stretch_l1a & phase_ok;   // aligned to low phase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/load_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_sequencer (
   input  wire logic                        WRCLK,
   input  wire logic                        srst,
   input  wire logic                        start,      // aligned trigger
   input  wire logic [cfeb_pkg::SMAX_W-1:0] samp_max,   // samples per event
   input  wire cfeb_pkg::grp_bus_t          grp,        // six group words
   output cfeb_pkg::fifo_wr_t               wr,         // to every channel fifo
   output logic                             busy        // capture in progress
);
   import cfeb_pkg::*;

   load_state_e       state;
   logic [SEL_W-1:0]  sel;         // current group, 0..N_GRP-1
   logic [SMAX_W-1:0] sample;      // samples finished so far
   logic              grp_last;    // last group of this sample
   logic              samp_last;   // this is the final sample
   group_word_t       muxout;      // selected group word

   assign grp_last = (sel == SEL_W'(N_GRP - 1));

   // one extra bit so the compare never wraps
   assign samp_last = ({1'b0, sample} + 1'b1) >= {1'b0, samp_max};

   ////////////////////////////////////////
   // load fsm and counters
   ////////////////////////////////////////
   always_ff @(posedge WRCLK or posedge srst) begin
      if (srst) begin
         state  <= IDLE;
         sel    <= '0;
         sample <= '0;
      end else begin
         case (state)
            IDLE: begin
               sel    <= '0;   // counters held clear
               sample <= '0;
               if (start) begin
                  state <= LOAD;
               end
            end
            LOAD: begin                     // start ignored here
               if (grp_last) begin
                  sel    <= '0;
                  sample <= sample + 1'b1;  // next sample after g6
                  if (samp_last) begin
                     state <= IDLE;         // samp_max * 6 writes done
                  end
               end else begin
                  sel <= sel + 1'b1;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // group multiplexer
   ////////////////////////////////////////
   always_comb begin
      case (sel)
         3'd0:    muxout = grp.g1;
         3'd1:    muxout = grp.g2;
         3'd2:    muxout = grp.g3;
         3'd3:    muxout = grp.g4;
         3'd4:    muxout = grp.g5;
         3'd5:    muxout = grp.g6;
         default: muxout = '0;   // unused codes
      endcase
   end

   // write every cycle spent in LOAD
   assign wr.en   = (state == LOAD);
   assign wr.data = muxout;
   assign busy    = (state == LOAD);

endmodule

`default_nettype wire

// ==== verilog/chan_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module chan_fifo #(
   parameter int DEPTH = 1024
) (
   input  wire logic                        WRCLK,
   input  wire logic                        srst,
   input  wire logic                        wr_en,
   input  wire logic [cfeb_pkg::SAMP_W-1:0] din,
   input  wire logic                        pop,     // advance head
   output logic      [cfeb_pkg::SAMP_W-1:0] dout,    // head word, fall-through
   output logic                             empty,
   output logic      [$clog2(DEPTH+1)-1:0]  count    // words held
);
   import cfeb_pkg::*;

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // pointer width
   localparam int CW = $clog2(DEPTH + 1);                 // occupancy width

   logic [SAMP_W-1:0] mem [DEPTH];
   logic [AW-1:0]     wr_ptr;
   logic [AW-1:0]     rd_ptr;
   logic              full;
   logic              do_wr;    // write accepted
   logic              do_pop;   // pop accepted

   // wrap at DEPTH, any depth allowed
   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] p);
      return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full   = (count == CW'(DEPTH));
   assign empty  = (count == '0);
   assign do_wr  = wr_en & ~full;   // full drops the word
   assign do_pop = pop & ~empty;
   assign dout   = mem[rd_ptr];     // head visible without a read

   always_ff @(posedge WRCLK) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge WRCLK or posedge srst) begin
      if (srst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({do_wr, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/wb_readout.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_readout (
   input  wire logic                      WRCLK,
   input  wire logic                      srst,
   input  wire cfeb_pkg::wb_req_t         req,       // classic wishbone request
   output cfeb_pkg::wb_rsp_t              rsp,
   input  wire cfeb_pkg::group_word_t     heads,     // all fifo head words
   input  wire logic [cfeb_pkg::N_CH-1:0] empties,
   output logic      [cfeb_pkg::N_CH-1:0] pop        // one-hot, ack cycle only
);
   import cfeb_pkg::*;

   logic              ack;
   logic              rd_ok;      // read of a channel holding data
   logic [SAMP_W-1:0] head_sel;   // addressed head word

   ////////////////////////////////////////
   // ack, one cycle after cyc & stb
   ////////////////////////////////////////
   always_ff @(posedge WRCLK or posedge srst) begin
      if (srst) begin
         ack <= 1'b0;
      end else begin
         ack <= req.cyc & req.stb & ~ack;   // never two in a row
      end
   end

   // master holds adr and we until ack
   assign head_sel = heads[req.adr * SAMP_W +: SAMP_W];
   assign rd_ok    = ack & ~req.we & ~empties[req.adr];

   assign rsp.ack = ack;
   assign rsp.dat = rd_ok ? head_sel : '0;   // empty channel reads zero

   ////////////////////////////////////////
   // pop decode
   ////////////////////////////////////////
   always_comb begin
      pop = '0;
      if (rd_ok) begin
         pop[req.adr] = 1'b1;   // head advances at end of ack
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cfeb_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cfeb_capture_top #(
   parameter int DEPTH    = 1024,   // words per channel fifo
   parameter int AE_LEVEL = 7       // rdy threshold on channel 0
) (
   input  wire logic                        WRCLK,
   input  wire logic                        srst,
   input  wire logic                        l1a_match,
   input  wire logic                        smpclk,
   input  wire logic [cfeb_pkg::SMAX_W-1:0] samp_max,
   input  wire cfeb_pkg::grp_bus_t          grp,
   input  wire cfeb_pkg::wb_req_t           wb_req,
   output cfeb_pkg::wb_rsp_t                wb_rsp,
   output logic                             rdy,       // ch0 above threshold
   output logic                             busy       // holds off triggers
);
   import cfeb_pkg::*;

   localparam int CW = $clog2(DEPTH + 1);

   logic            start;          // aligned trigger pulse
   fifo_wr_t        wr;             // shared write bus
   group_word_t     heads;          // fifo heads, ch0 low
   logic [N_CH-1:0] empties;
   logic [N_CH-1:0] pop;
   logic [CW-1:0]   counts [N_CH];

   ////////////////////////////////////////
   // trigger and load control
   ////////////////////////////////////////
   trigger_align u_trig (
      .WRCLK     (WRCLK),
      .srst      (srst),
      .l1a_match (l1a_match),
      .smpclk    (smpclk),
      .start     (start)
   );

   load_sequencer u_load (
      .WRCLK    (WRCLK),
      .srst     (srst),
      .start    (start),
      .samp_max (samp_max),
      .grp      (grp),
      .wr       (wr),
      .busy     (busy)
   );

   ////////////////////////////////////////
   // channel fifo bank
   ////////////////////////////////////////
   for (genvar c = 0; c < N_CH; c++) begin : g_fifo
      chan_fifo #(
         .DEPTH (DEPTH)
      ) u_fifo (
         .WRCLK (WRCLK),
         .srst  (srst),
         .wr_en (wr.en),                          // same enable for all
         .din   (wr.data[c*SAMP_W +: SAMP_W]),    // own 12-bit slice
         .pop   (pop[c]),
         .dout  (heads[c*SAMP_W +: SAMP_W]),
         .empty (empties[c]),
         .count (counts[c])
      );
   end

   ////////////////////////////////////////
   // host readout
   ////////////////////////////////////////
   wb_readout u_wb (
      .WRCLK   (WRCLK),
      .srst    (srst),
      .req     (wb_req),
      .rsp     (wb_rsp),
      .heads   (heads),
      .empties (empties),
      .pop     (pop)
   );

   // all channels fill together, ch0 stands for the board
   assign rdy = (counts[0] > CW'(AE_LEVEL));

endmodule

`default_nettype wire

// ==== sim/cfeb_capture_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module cfeb_capture_chk (
   input wire logic WRCLK,
   input wire logic srst,
   input wire logic start,   // aligned trigger pulse
   input wire logic busy,
   input wire logic wr_en,   // shared fifo write enable
   input wire logic ack      // wishbone ack
);

   ////////////////////////////////////////
   // protocol and sequencing properties
   ////////////////////////////////////////
   ack_single: assert property (@(posedge WRCLK) disable iff (srst)
      ack |=> !ack)
      else $error("ack held for two cycles");

   busy_after_start: assert property (@(posedge WRCLK) disable iff (srst)
      $rose(busy) |-> $past(start))
      else $error("busy rose with no start the cycle before");

   wr_inside_busy: assert property (@(posedge WRCLK) disable iff (srst)
      $rose(wr_en) |-> busy)
      else $error("write enable rose outside a capture");

endmodule

`default_nettype wire

// ==== sim/cfeb_scoreboard.sv ====
`timescale 1ns/100ps
`default_nettype none

module cfeb_scoreboard #(
   parameter int AE_LEVEL = 7   // rdy threshold on channel 0
) (
   input wire logic                        WRCLK,
   input wire logic                        srst,
   input wire logic                        l1a_match,
   input wire logic                        smpclk,
   input wire logic [cfeb_pkg::SMAX_W-1:0] samp_max,
   input wire cfeb_pkg::grp_bus_t          grp,
   input wire cfeb_pkg::wb_req_t           wb_req,
   input wire cfeb_pkg::wb_rsp_t           wb_rsp,
   input wire logic                        rdy,
   input wire logic                        busy
);
   import cfeb_pkg::*;

   int                err_count = 0;       // wrong values seen
   int                rd_count  = 0;       // acked reads compared
   logic [SAMP_W-1:0] model_q [N_CH][$];   // expected fifo contents
   logic              busy_q;
   logic              srst_q;
   logic [3:0]        smp_hist;            // last smpclk samples
   logic [3:0]        l1a_hist;            // last l1a_match samples
   int                req_age;             // cycles a request has waited

   task automatic report_err(input string msg);
      $display("ERR %0t: %s", $time, msg);
      err_count++;
   endtask

   // word k of channel c is slice c of group (k mod 6) + 1
   task automatic push_event();
      group_word_t w;
      for (int k = 0; k < samp_max * N_GRP; k++) begin
         case (k % N_GRP)
            0:       w = grp.g1;
            1:       w = grp.g2;
            2:       w = grp.g3;
            3:       w = grp.g4;
            4:       w = grp.g5;
            default: w = grp.g6;
         endcase
         for (int c = 0; c < N_CH; c++) begin
            model_q[c].push_back(w[c*SAMP_W +: SAMP_W]);
         end
      end
   endtask

   ////////////////////////////////////////
   // per-cycle comparisons
   ////////////////////////////////////////
   always @(posedge WRCLK) begin
      logic [SAMP_W-1:0] exp_dat;
      int                ch;
      if (srst) begin
         busy_q   = 1'b0;
         srst_q   = 1'b1;
         req_age  = 0;
         smp_hist = '0;
         l1a_hist = '0;
         for (int c = 0; c < N_CH; c++) begin
            model_q[c].delete();
         end
      end else begin
         if (srst_q && (busy || rdy || wb_rsp.ack)) begin
            report_err("outputs not idle after reset");
         end
         srst_q   = 1'b0;
         smp_hist = {smp_hist[2:0], smpclk};
         l1a_hist = {l1a_hist[2:0], l1a_match};
         if (busy && !busy_q) begin                   // one event per rise
            if (&smp_hist) begin
               report_err("capture started with smpclk held high");
            end
            if (l1a_hist == '0) begin                 // no fresh trigger
               report_err("busy rose with no trigger just before");
            end
            push_event();
         end
         busy_q = busy;
         // fifo counts settle once busy is low
         if (!busy && (rdy !== (model_q[0].size() > AE_LEVEL))) begin
            report_err($sformatf("rdy %0b with %0d words in channel 0",
                                 rdy, model_q[0].size()));
         end
         if (wb_rsp.ack) begin
            if (req_age != 1) begin
               report_err($sformatf("ack after %0d cycles", req_age));
            end
            req_age = 0;
            if (!wb_req.we) begin                     // writes leave model alone
               ch      = wb_req.adr;
               exp_dat = '0;                          // empty reads zero
               if (model_q[ch].size() > 0) begin
                  exp_dat = model_q[ch].pop_front();
               end
               rd_count++;
               if (wb_rsp.dat !== exp_dat) begin
                  report_err($sformatf("ch %0d read %h, expected %h",
                                       ch, wb_rsp.dat, exp_dat));
               end
            end
         end else if (wb_req.cyc && wb_req.stb) begin
            req_age++;
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_cfeb_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cfeb_capture;
   import cfeb_pkg::*;

   localparam int DEPTH    = 1024;
   localparam int AE_LEVEL = 7;
   localparam int N_EVENTS = 8;     // captures per run
   localparam int TMO      = 200;   // cycles allowed per wait

   logic              WRCLK;
   logic              srst;
   logic              l1a_match;
   logic              smpclk;
   logic [SMAX_W-1:0] samp_max;
   grp_bus_t          grp;
   wb_req_t           wb_req;
   wb_rsp_t           wb_rsp;
   logic              rdy;
   logic              busy;
   int                seed;
   int                tmo_count;    // waits that ran out

   cfeb_capture_top #(
      .DEPTH    (DEPTH),
      .AE_LEVEL (AE_LEVEL)
   ) dut (
      .WRCLK     (WRCLK),
      .srst      (srst),
      .l1a_match (l1a_match),
      .smpclk    (smpclk),
      .samp_max  (samp_max),
      .grp       (grp),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .rdy       (rdy),
      .busy      (busy)
   );

   cfeb_scoreboard #(
      .AE_LEVEL (AE_LEVEL)
   ) sb (
      .WRCLK     (WRCLK),
      .srst      (srst),
      .l1a_match (l1a_match),
      .smpclk    (smpclk),
      .samp_max  (samp_max),
      .grp       (grp),
      .wb_req    (wb_req),
      .wb_rsp    (wb_rsp),
      .rdy       (rdy),
      .busy      (busy)
   );

   bind cfeb_capture_top cfeb_capture_chk u_chk (
      .WRCLK (WRCLK),
      .srst  (srst),
      .start (start),
      .busy  (busy),
      .wr_en (wr.en),
      .ack   (wb_rsp.ack)
   );

   initial begin
      WRCLK = 1'b0;
      forever #2 WRCLK = ~WRCLK;   // 4 ns period
   end

   // fresh group words and sample count while busy is low
   task automatic new_event_inputs();
      grp_bus_t g;
      for (int i = 0; i < $bits(grp_bus_t) / 32; i++) begin
         g[i*32 +: 32] = $random(seed);
      end
      @(posedge WRCLK);
      grp      <= g;
      samp_max <= SMAX_W'(1 + $unsigned($random(seed)) % 20);   // 1..20
   endtask

   task automatic fire_trigger();
      @(posedge WRCLK);
      l1a_match <= 1'b1;
      @(posedge WRCLK);
      l1a_match <= 1'b0;
   endtask

   task automatic wait_busy(input logic level);
      bit seen;
      seen = 1'b0;
      for (int i = 0; i < TMO && !seen; i++) begin
         @(posedge WRCLK);
         seen = (busy == level);
      end
      if (!seen) begin
         $display("timeout waiting for busy to become %0b at %0t", level, $time);
         tmo_count++;
      end
   endtask

   task automatic wb_access(input logic wr, input int adr);
      bit got;
      got = 1'b0;
      @(posedge WRCLK);
      wb_req <= '{cyc: 1'b1, stb: 1'b1, we: wr, adr: ADR_W'(adr)};
      for (int i = 0; i < TMO && !got; i++) begin
         @(posedge WRCLK);
         got = wb_rsp.ack;
      end
      wb_req <= '0;   // dropped on the ack edge
      if (!got) begin
         $display("timeout waiting for ack on channel %0d at %0t", adr, $time);
         tmo_count++;
      end
   endtask

   // n reads per channel plus one past the end
   task automatic drain_channels(input int n);
      for (int c = 0; c < N_CH; c++) begin
         for (int k = 0; k <= n; k++) begin
            wb_access(1'b0, c);
         end
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      seed      = 32'h9584_9851;
      tmo_count = 0;
      srst      = 1'b1;
      l1a_match = 1'b0;
      smpclk    = 1'b0;
      samp_max  = SMAX_W'(1);
      grp       = '0;
      wb_req    = '0;
      repeat (4) @(posedge WRCLK);
      srst <= 1'b0;
      drain_channels(0);                       // empty fifos read zero
      for (int ev = 0; ev < N_EVENTS; ev++) begin
         new_event_inputs();
         repeat (3) @(posedge WRCLK);          // synced smpclk settles low
         fire_trigger();
         wait_busy(1'b1);
         fire_trigger();                       // lands inside LOAD
         wait_busy(1'b0);
         if (($random(seed) & 3) == 0) begin
            wb_access(1'b1, $unsigned($random(seed)) % N_CH);
         end
         drain_channels(samp_max * N_GRP);
      end
      // trigger with the sample clock high throughout
      @(posedge WRCLK);
      smpclk <= 1'b1;
      repeat (4) @(posedge WRCLK);
      fire_trigger();
      repeat (TMO) @(posedge WRCLK);           // busy must stay low
      smpclk <= 1'b0;
      drain_channels(0);
      $display("reads %0d, errors %0d, timeouts %0d",
               sb.rd_count, sb.err_count, tmo_count);
      if (sb.err_count == 0 && tmo_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/cfeb_pkg.sv
verilog/trigger_align.sv
verilog/load_sequencer.sv
verilog/chan_fifo.sv
verilog/wb_readout.sv
verilog/cfeb_capture_top.sv
sim/cfeb_capture_chk.sv
sim/cfeb_scoreboard.sv
sim/tb_cfeb_capture.sv

// ==== Bender.yml ====
package:
  name: cfeb_capture

sources:
  - verilog/cfeb_pkg.sv
  - verilog/trigger_align.sv
  - verilog/load_sequencer.sv
  - verilog/chan_fifo.sv
  - verilog/wb_readout.sv
  - verilog/cfeb_capture_top.sv
  - target: simulation
    files:
      - sim/cfeb_capture_chk.sv
      - sim/cfeb_scoreboard.sv
      - sim/tb_cfeb_capture.sv
